// ==== logic/bus_pkg.sv ====
package bus_pkg;

    localparam int ADDR_BITS = 32;
    localparam int DATA_BITS = 32;
    localparam int STRB_BITS = DATA_BITS / 8;

    // System bus address
    typedef logic [ADDR_BITS-1:0] addr_t;

    // One bus word
    typedef logic [DATA_BITS-1:0] data_t;

    // Byte write enables, one per byte lane
    typedef logic [STRB_BITS-1:0] strb_t;

    // RAM region
    // Offset bits are cleared with the mask before comparing to the base
    localparam addr_t RAM_BASE = 32'h0000_0000;
    localparam addr_t RAM_MASK = 32'h0000_FFFF;

endpackage

// ==== logic/cache_pkg.sv ====
package cache_pkg;

    // Lines per way
    localparam int L1_LINES = 64;

    // Line index into every tag and block RAM
    typedef logic [$clog2(L1_LINES)-1:0] line_t;

    // Tag width
    localparam int TAG_BITS = 22;

    typedef logic [TAG_BITS-1:0] tag_t;

    // One cache block, four bus words
    localparam int BLOCK_BITS = 128;

    typedef logic [BLOCK_BITS-1:0] block_t;

endpackage

// ==== logic/bram_model.sv ====
`timescale 1ns/1ps

module bram_model #(
    parameter int DATA_WIDTH = 32,
    parameter int DEPTH      = 64,
    parameter int LATENCY    = 2
) (
    input  logic                  clk,
    input  logic                  en_i,
    input  logic                  we_i,
    input  cache_pkg::line_t      addr_i,
    input  logic [DATA_WIDTH-1:0] data_i,
    output logic [DATA_WIDTH-1:0] data_o
);

    logic [DATA_WIDTH-1:0] mem [DEPTH];

    // Read pipeline, stage 0 is loaded from the array
    logic [DATA_WIDTH-1:0] pipe_q [LATENCY];

    always_ff @(posedge clk) begin
        if (en_i && we_i) begin
            mem[addr_i] <= data_i;
        end
        if (en_i && !we_i) begin
            pipe_q[0] <= mem[addr_i];
        end
        for (int i = 1; i < LATENCY; i++) begin
            pipe_q[i] <= pipe_q[i-1];
        end
    end

    assign data_o = pipe_q[LATENCY-1];

endmodule

// ==== logic/l1_way_array.sv ====
`timescale 1ns/1ps

module l1_way_array #(
    parameter int L1_WAYS    = 2,
    parameter int L1_LATENCY = 2
) (
    input  logic                                clk,
    input  logic                                resetn,

    // Command side
    input  logic                                cmd_valid_i,
    input  cache_pkg::line_t                    line_i,
    input  logic [L1_WAYS-1:0]                  way_write_i,
    input  cache_pkg::tag_t   [L1_WAYS-1:0]     tag_wdata_i,
    input  cache_pkg::block_t [L1_WAYS-1:0]     block_wdata_i,

    // Read side
    output cache_pkg::tag_t   [L1_WAYS-1:0]     tag_o,
    output cache_pkg::block_t [L1_WAYS-1:0]     block_o,
    output logic                                rd_valid_o
);

    import cache_pkg::*;

    logic                  rd_cmd;
    logic [L1_LATENCY-1:0] rd_pipe_q;

    // A read is a command with no way selected for writing
    assign rd_cmd = cmd_valid_i && !(|way_write_i);

    // Flag delay line, matched to the RAM output pipeline
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rd_pipe_q <= '0;
        end else begin
            rd_pipe_q[0] <= rd_cmd;
            for (int i = 1; i < L1_LATENCY; i++) begin
                rd_pipe_q[i] <= rd_pipe_q[i-1];
            end
        end
    end

    assign rd_valid_o = rd_pipe_q[L1_LATENCY-1];

    // Tag and block RAM per way
    for (genvar w = 0; w < L1_WAYS; w++) begin : g_way
        bram_model #(
            .DATA_WIDTH (TAG_BITS),
            .DEPTH      (L1_LINES),
            .LATENCY    (L1_LATENCY)
        ) u_tag_ram (
            .clk    (clk),
            .en_i   (cmd_valid_i),
            .we_i   (way_write_i[w]),
            .addr_i (line_i),
            .data_i (tag_wdata_i[w]),
            .data_o (tag_o[w])
        );

        bram_model #(
            .DATA_WIDTH (BLOCK_BITS),
            .DEPTH      (L1_LINES),
            .LATENCY    (L1_LATENCY)
        ) u_block_ram (
            .clk    (clk),
            .en_i   (cmd_valid_i),
            .we_i   (way_write_i[w]),
            .addr_i (line_i),
            .data_i (block_wdata_i[w]),
            .data_o (block_o[w])
        );
    end

endmodule

// ==== logic/mem_bus_bridge.sv ====
`timescale 1ns/1ps

module mem_bus_bridge (
    input  logic             clk,
    input  logic             resetn,

    // Requester side
    input  logic             req_valid_i,
    input  logic             req_write_i,
    input  bus_pkg::addr_t   req_addr_i,
    input  bus_pkg::data_t   req_wdata_i,
    output logic             req_ready_o,

    // Response side
    output bus_pkg::data_t   resp_data_o,
    output logic             resp_valid_o,

    // External RAM
    output logic             iomem_valid,
    input  logic             iomem_ready,
    output bus_pkg::addr_t   iomem_addr,
    output bus_pkg::data_t   iomem_wdata,
    output bus_pkg::strb_t   iomem_wstrb,
    input  bus_pkg::data_t   iomem_rdata
);

    import bus_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUSY,
        ST_RESP
    } state_t;

    state_t state_q;
    state_t state_d;

    logic   in_ram;
    logic   accept;

    // Held request
    addr_t  addr_q;
    data_t  wdata_q;
    logic   write_q;

    // Read data taken in the ready cycle
    data_t  rdata_q;

    // Only the RAM region is decoded, anything else waits forever
    assign in_ram = (req_addr_i & ~RAM_MASK) == RAM_BASE;

    assign req_ready_o = (state_q == ST_IDLE) && in_ram;
    assign accept      = req_valid_i && req_ready_o;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (accept) begin
                    state_d = ST_BUSY;
                end
            end
            ST_BUSY: begin
                if (iomem_ready) begin
                    // Writes need no response
                    state_d = write_q ? ST_IDLE : ST_RESP;
                end
            end
            ST_RESP: begin
                state_d = ST_IDLE;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q  <= req_addr_i;
            wdata_q <= req_wdata_i;
            write_q <= req_write_i;
        end
        if (state_q == ST_BUSY && iomem_ready) begin
            rdata_q <= iomem_rdata;
        end
    end

    // Request stays stable for the whole busy phase
    assign iomem_valid = (state_q == ST_BUSY);
    assign iomem_addr  = addr_q;
    assign iomem_wdata = wdata_q;
    assign iomem_wstrb = {$bits(strb_t){write_q}};

    assign resp_valid_o = (state_q == ST_RESP);
    assign resp_data_o  = rdata_q;

endmodule

// ==== logic/soc_memory_top.sv ====
`timescale 1ns/1ps

module soc_memory_top #(
    parameter int L1_WAYS    = 2,
    parameter int L1_LATENCY = 2
) (
    input  logic                                clk,
    input  logic                                resetn,

    // L1 way array
    input  logic                                arr_cmd_valid_i,
    input  cache_pkg::line_t                    arr_line_i,
    input  logic [L1_WAYS-1:0]                  arr_way_write_i,
    input  cache_pkg::tag_t   [L1_WAYS-1:0]     arr_tag_wdata_i,
    input  cache_pkg::block_t [L1_WAYS-1:0]     arr_block_wdata_i,
    output cache_pkg::tag_t   [L1_WAYS-1:0]     arr_tag_o,
    output cache_pkg::block_t [L1_WAYS-1:0]     arr_block_o,
    output logic                                arr_rd_valid_o,

    // Bus requester
    input  logic                                req_valid_i,
    input  logic                                req_write_i,
    input  bus_pkg::addr_t                      req_addr_i,
    input  bus_pkg::data_t                      req_wdata_i,
    output logic                                req_ready_o,
    output bus_pkg::data_t                      resp_data_o,
    output logic                                resp_valid_o,

    // External RAM bus
    output logic                                iomem_valid,
    input  logic                                iomem_ready,
    output bus_pkg::addr_t                      iomem_addr,
    output bus_pkg::data_t                      iomem_wdata,
    output bus_pkg::strb_t                      iomem_wstrb,
    input  bus_pkg::data_t                      iomem_rdata
);

    l1_way_array #(
        .L1_WAYS    (L1_WAYS),
        .L1_LATENCY (L1_LATENCY)
    ) u_way_array (
        .clk           (clk),
        .resetn        (resetn),
        .cmd_valid_i   (arr_cmd_valid_i),
        .line_i        (arr_line_i),
        .way_write_i   (arr_way_write_i),
        .tag_wdata_i   (arr_tag_wdata_i),
        .block_wdata_i (arr_block_wdata_i),
        .tag_o         (arr_tag_o),
        .block_o       (arr_block_o),
        .rd_valid_o    (arr_rd_valid_o)
    );

    mem_bus_bridge u_bridge (
        .clk          (clk),
        .resetn       (resetn),
        .req_valid_i  (req_valid_i),
        .req_write_i  (req_write_i),
        .req_addr_i   (req_addr_i),
        .req_wdata_i  (req_wdata_i),
        .req_ready_o  (req_ready_o),
        .resp_data_o  (resp_data_o),
        .resp_valid_o (resp_valid_o),
        .iomem_valid  (iomem_valid),
        .iomem_ready  (iomem_ready),
        .iomem_addr   (iomem_addr),
        .iomem_wdata  (iomem_wdata),
        .iomem_wstrb  (iomem_wstrb),
        .iomem_rdata  (iomem_rdata)
    );

endmodule

// ==== testbench/soc_memory_asserts.sv ====
`timescale 1ns/1ps

module soc_memory_asserts #(
    parameter int L1_WAYS    = 2,
    parameter int L1_LATENCY = 2
) (
    input logic                 clk,
    input logic                 resetn,
    input logic                 arr_cmd_valid_i,
    input logic [L1_WAYS-1:0]   arr_way_write_i,
    input logic                 arr_rd_valid_o,
    input logic                 req_valid_i,
    input logic                 req_write_i,
    input bus_pkg::addr_t       req_addr_i,
    input logic                 req_ready_o,
    input logic                 resp_valid_o,
    input logic                 iomem_valid,
    input logic                 iomem_ready,
    input bus_pkg::addr_t       iomem_addr,
    input bus_pkg::data_t       iomem_wdata,
    input bus_pkg::strb_t       iomem_wstrb
);

    import bus_pkg::*;

    int   fail_count = 0;
    logic rd_cmd;
    logic in_ram;
    logic rd_done;

    assign rd_cmd  = arr_cmd_valid_i && !(|arr_way_write_i);
    assign in_ram  = (req_addr_i & ~RAM_MASK) == RAM_BASE;
    assign rd_done = iomem_valid && iomem_ready && (iomem_wstrb == '0);

    task automatic record_failure(input string what);
        fail_count++;
        $error("%s", what);
    endtask

    // Array read flag
    a_rd_valid_after_read: assert property (@(posedge clk) disable iff (!resetn)
        rd_cmd |-> ##L1_LATENCY arr_rd_valid_o)
        else record_failure("arr_rd_valid_o missing after a read command");
    a_rd_valid_only_after_read: assert property (@(posedge clk) disable iff (!resetn)
        arr_rd_valid_o |-> $past(rd_cmd, L1_LATENCY))
        else record_failure("arr_rd_valid_o without a matching read command");

    // RAM request held until ready
    a_request_held: assert property (@(posedge clk) disable iff (!resetn)
        iomem_valid && !iomem_ready |=> iomem_valid && $stable(iomem_addr)
            && $stable(iomem_wdata) && $stable(iomem_wstrb))
        else record_failure("RAM request changed while waiting for iomem_ready");
    a_valid_drops: assert property (@(posedge clk) disable iff (!resetn)
        iomem_valid && iomem_ready |=> !iomem_valid)
        else record_failure("iomem_valid stayed high after iomem_ready");
    a_strobes: assert property (@(posedge clk) disable iff (!resetn)
        $rose(iomem_valid) |-> $past(req_valid_i && req_ready_o)
            && iomem_wstrb == {$bits(strb_t){$past(req_write_i)}})
        else record_failure("RAM request start or strobes do not match the accepted request");
    a_no_ready_when_busy: assert property (@(posedge clk) disable iff (!resetn)
        iomem_valid |-> !req_ready_o)
        else record_failure("req_ready_o high while a transfer is outstanding");

    // Read response one cycle after the ready of a read
    a_resp_after_read: assert property (@(posedge clk) disable iff (!resetn)
        rd_done |=> resp_valid_o)
        else record_failure("resp_valid_o missing after a read completed");
    a_resp_only_after_read: assert property (@(posedge clk) disable iff (!resetn)
        resp_valid_o |-> $past(rd_done))
        else record_failure("resp_valid_o without a completed read");

    // Decode
    a_no_ready_outside: assert property (@(posedge clk) disable iff (!resetn)
        !in_ram |-> !req_ready_o)
        else record_failure("req_ready_o high for an address outside the RAM region");
    a_no_start_outside: assert property (@(posedge clk) disable iff (!resetn)
        req_valid_i && !in_ram && !iomem_valid |=> !iomem_valid)
        else record_failure("iomem_valid raised for an address outside the RAM region");

    a_reset_state: assert property (@(posedge clk)
        $rose(resetn) |-> !iomem_valid && !resp_valid_o && !arr_rd_valid_o)
        else record_failure("outputs not idle after reset");

endmodule

bind soc_memory_top soc_memory_asserts #(
    .L1_WAYS    (L1_WAYS),
    .L1_LATENCY (L1_LATENCY)
) u_asserts (.*);

// ==== testbench/tb_soc_memory.sv ====
`timescale 1ns/1ps

module tb_soc_memory;

    import bus_pkg::*;
    import cache_pkg::*;

    localparam int WAYS           = 2;
    localparam int LATENCY        = 2;
    localparam int BUS_WORDS      = 32;
    localparam int TIMEOUT_CYCLES = 2000;

    logic               clk;
    logic               resetn;
    logic               arr_cmd_valid_i;
    line_t              arr_line_i;
    logic [WAYS-1:0]    arr_way_write_i;
    tag_t   [WAYS-1:0]  arr_tag_wdata_i;
    block_t [WAYS-1:0]  arr_block_wdata_i;
    tag_t   [WAYS-1:0]  arr_tag_o;
    block_t [WAYS-1:0]  arr_block_o;
    logic               arr_rd_valid_o;
    logic               req_valid_i;
    logic               req_write_i;
    addr_t              req_addr_i;
    data_t              req_wdata_i;
    logic               req_ready_o;
    data_t              resp_data_o;
    logic               resp_valid_o;
    logic               iomem_valid;
    logic               iomem_ready;
    addr_t              iomem_addr;
    data_t              iomem_wdata;
    strb_t              iomem_wstrb;
    data_t              iomem_rdata;

    logic [31:0] lfsr = 32'd78368;
    int          cycle_count = 0;

    data_t ram_words [addr_t];
    data_t expected_words [addr_t];
    addr_t written_q [$];

    // Array contents as written and expected results of reads in flight
    tag_t   [WAYS-1:0] shadow_tag   [L1_LINES];
    block_t [WAYS-1:0] shadow_block [L1_LINES];
    line_t             exp_line_q  [$];
    tag_t   [WAYS-1:0] exp_tag_q   [$];
    block_t [WAYS-1:0] exp_block_q [$];

    soc_memory_top #(.L1_WAYS(WAYS), .L1_LATENCY(LATENCY)) DUT (.*);

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            bits[i] = lfsr[0];
        end
        return bits;
    endfunction

    function automatic block_t random_block();
        return {random_bits(32), random_bits(32), random_bits(32), random_bits(32)};
    endfunction

    task automatic compare_value(input string name, input logic [BLOCK_BITS-1:0] expected,
                                 input logic [BLOCK_BITS-1:0] actual);
        if (actual !== expected) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (DUT.u_asserts.fail_count != 0) begin
            $display("A protocol assertion failed, see the error above");
            $display("*** TEST FAILED ***");
            $fatal(1, "assertion failure");
        end else if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** TEST FAILED ***");
            $fatal(1, "timeout");
        end
    end

    // External RAM model with a ready delay of 0 to 3 cycles
    initial begin : ram_model
        int delay;
        forever begin
            @(posedge clk);
            #1;
            iomem_ready = 1'b0;
            if (iomem_valid) begin
                delay = random_bits(2);
                wait_cycles(delay);
                if (iomem_wstrb == '1) begin
                    ram_words[iomem_addr] = iomem_wdata;
                end else if (ram_words.exists(iomem_addr)) begin
                    iomem_rdata = ram_words[iomem_addr];
                end else begin
                    iomem_rdata = iomem_addr ^ 32'hA5C3_0F96;
                end
                iomem_ready = 1'b1;
            end
        end
    end

    initial begin : array_monitor
        forever begin
            @(posedge clk);
            #1;
            if (arr_rd_valid_o && exp_line_q.size() != 0) begin
                for (int w = 0; w < WAYS; w++) begin
                    compare_value($sformatf("array_read line %0d way %0d tag", exp_line_q[0], w),
                                  exp_tag_q[0][w], arr_tag_o[w]);
                    compare_value($sformatf("array_read line %0d way %0d block", exp_line_q[0], w),
                                  exp_block_q[0][w], arr_block_o[w]);
                end
                void'(exp_line_q.pop_front());
                void'(exp_tag_q.pop_front());
                void'(exp_block_q.pop_front());
            end
        end
    end

    // Unselected ways get random data too and must ignore it
    task automatic array_write(input line_t line, input logic [WAYS-1:0] ways);
        for (int w = 0; w < WAYS; w++) begin
            arr_tag_wdata_i[w]   = tag_t'(random_bits(TAG_BITS));
            arr_block_wdata_i[w] = random_block();
            if (ways[w]) begin
                shadow_tag[line][w]   = arr_tag_wdata_i[w];
                shadow_block[line][w] = arr_block_wdata_i[w];
            end
        end
        arr_cmd_valid_i = 1'b1;
        arr_line_i      = line;
        arr_way_write_i = ways;
        wait_cycles(1);
        arr_cmd_valid_i = 1'b0;
        arr_way_write_i = '0;
    endtask

    task automatic array_read(input line_t line);
        exp_line_q.push_back(line);
        exp_tag_q.push_back(shadow_tag[line]);
        exp_block_q.push_back(shadow_block[line]);
        arr_cmd_valid_i = 1'b1;
        arr_line_i      = line;
        arr_way_write_i = '0;
        wait_cycles(1);
        arr_cmd_valid_i = 1'b0;
    endtask

    task automatic bus_request(input logic write, input addr_t addr, input data_t wdata);
        req_valid_i = 1'b1;
        req_write_i = write;
        req_addr_i  = addr;
        req_wdata_i = wdata;
        #1;
        while (!req_ready_o) begin
            @(posedge clk);
            #2;
        end
        @(posedge clk);
        #1;
        req_valid_i = 1'b0;
    endtask

    task automatic bus_read(input addr_t addr);
        bus_request(1'b0, addr, '0);
        while (!resp_valid_o) begin
            wait_cycles(1);
        end
        compare_value($sformatf("bus_read %h", addr), expected_words[addr], resp_data_o);
    endtask

    initial begin
        addr_t addr;
        data_t data;
        clk               = 1'b0;
        resetn            = 1'b0;
        arr_cmd_valid_i   = 1'b0;
        arr_line_i        = '0;
        arr_way_write_i   = '0;
        arr_tag_wdata_i   = '0;
        arr_block_wdata_i = '0;
        req_valid_i       = 1'b0;
        req_write_i       = 1'b0;
        req_addr_i        = '0;
        req_wdata_i       = '0;
        iomem_ready       = 1'b0;
        iomem_rdata       = '0;
        repeat (10) @(posedge clk);
        #1;
        resetn = 1'b1;

        // Fill both ways and then overwrite one way per line
        for (int l = 0; l < 6; l++) begin
            array_write(line_t'(l * 9), 2'b11);
        end
        for (int l = 0; l < 6; l++) begin
            array_write(line_t'(l * 9), (l % 2) ? 2'b10 : 2'b01);
        end
        for (int l = 0; l < 6; l++) begin
            array_read(line_t'(l * 9));
        end
        wait_cycles(3);
        // A write right behind a read must not change that read
        for (int l = 0; l < 6; l++) begin
            array_read(line_t'(l * 9));
            array_write(line_t'(l * 9), (l % 2) ? 2'b01 : 2'b10);
            array_read(line_t'(l * 9));
        end
        while (exp_line_q.size() != 0) begin
            wait_cycles(1);
        end

        for (int i = 0; i < BUS_WORDS; i++) begin
            addr = RAM_BASE | (addr_t'(random_bits(14)) << 2);
            data = random_bits(32);
            bus_request(1'b1, addr, data);
            expected_words[addr] = data;
            written_q.push_back(addr);
        end
        foreach (written_q[i]) begin
            bus_read(written_q[i]);
        end

        // Each written word must sit at its own address in the RAM
        foreach (expected_words[waddr]) begin
            if (!ram_words.exists(waddr)) begin
                $display("The RAM never received a write at address %h", waddr);
                $display("*** TEST FAILED ***");
                $fatal(1, "missing RAM word");
            end
            compare_value($sformatf("ram_write %h", waddr), expected_words[waddr],
                          ram_words[waddr]);
        end

        // Address just above the RAM region held for 20 cycles
        req_valid_i = 1'b1;
        req_write_i = 1'b0;
        req_addr_i  = 32'h0001_2340;
        wait_cycles(20);
        req_valid_i = 1'b0;
        req_addr_i  = '0;

        wait_cycles(4);
        if (DUT.u_asserts.fail_count == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("*** TEST FAILED ***");
            $fatal(1, "protocol assertions failed");
        end
    end

endmodule

// ==== project.f ====
logic/bus_pkg.sv
logic/cache_pkg.sv
logic/bram_model.sv
logic/l1_way_array.sv
logic/mem_bus_bridge.sv
logic/soc_memory_top.sv
testbench/soc_memory_asserts.sv
testbench/tb_soc_memory.sv

// ==== Bender.yml ====
package:
  name: soc_memory

sources:
  - files:
      - logic/bus_pkg.sv
      - logic/cache_pkg.sv
      - logic/bram_model.sv
      - logic/l1_way_array.sv
      - logic/mem_bus_bridge.sv
      - logic/soc_memory_top.sv
  - target: test
    files:
      - testbench/soc_memory_asserts.sv
      - testbench/tb_soc_memory.sv
